// File: common/sys6809_pkg.sv
// bus widths, work RAM size, missed-slot counter width
// and the wait-state encoding for the 6809 bus front end
package sys6809_pkg;

    // core address bus
    localparam int addr_w = 16;

    // byte-wide data bus
    localparam int data_w = 8;

    // work RAM address width, 4 KiB
    localparam int ram_aw = 12;

    // missed-slot counter, saturates at 15
    localparam int miss_w = 4;

    // wait state machine
    // idle      gate open, no transfer pending
    // rom_req   request raised, address held
    // rom_rel   ack seen, request dropped, waiting for ack low
    // bus_hold  shared bus owned by another master
    typedef enum logic [1:0] {
        idle     = 2'd0,
        rom_req  = 2'd1,
        rom_rel  = 2'd2,
        bus_hold = 2'd3
    } wait_state_t;

endpackage

// File: source/cen_phase_gen.sv
// E/Q clock enable generator with missed-slot counting
// and recovery of lost slots after a stall
`timescale 1ns/1ps

module cen_phase_gen
    import sys6809_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    // input clock strobe of the core
    input  logic cen,
    // low while the bus front end stalls the core
    input  logic gate,
    output logic cen_e,
    output logic cen_q
);

    // four strobes per core cycle
    // E at phase 0, Q at phase 2
    logic [1:0] phase;

    // slots lost while gate was low
    logic [miss_w-1:0] misses;

    logic gated;
    logic slot_now;
    logic in_debt;
    logic miss_full;

    // strobe that actually reaches the core
    // nothing passes while reset is held
    assign gated = cen & gate & rstn;

    // even phase carries an enable
    assign slot_now = ~phase[0];

    assign in_debt   = misses != '0;
    assign miss_full = misses == '1;

    // enables are combinational so they line up with cen
    assign cen_e = gated & (phase == 2'd0);
    assign cen_q = gated & (phase == 2'd2);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            phase  <= 2'd0;
            misses <= '0;
        end else if (cen) begin
            if (gate) begin
                if (in_debt && slot_now) begin
                    // enable fires now, skip the odd slot
                    // so the next enable is one strobe away
                    phase  <= {~phase[1], 1'b0};
                    misses <= misses - 1'b1;
                end else begin
                    // normal cadence, two strobes per enable
                    phase <= phase + 2'd1;
                end
            end else begin
                // phase frozen while stalled
                // an enable slot passing by is a miss
                if (slot_now && !miss_full) begin
                    misses <= misses + 1'b1;
                end
            end
        end
    end

    // gate low never advances the phase, so the core sees
    // no partial cycle while the bus is held
    // with debt, odd phases are skipped entirely; an odd
    // phase can only be current if the stall began there,
    // in which case the next gated strobe lands on even

endmodule

// File: source/bus_wait_fsm.sv
// wait state machine for bus sharing and ROM fetch
// gates the core enables and runs the four-phase SDRAM request
`timescale 1ns/1ps

module bus_wait_fsm
    import sys6809_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    // another master owns the shared bus
    input  logic              bus_busy,
    input  logic              rom_cs,
    input  logic [addr_w-1:0] addr,
    // SDRAM side handshake
    input  logic              rom_ack,
    output logic              rom_req,
    output logic [addr_w-1:0] rom_addr,
    // one clock pulse, rom_data is valid
    output logic              rom_latch,
    // high lets the enables through
    output logic              gate
);

    wait_state_t state;

    // address of the byte held in the data path
    logic [addr_w-1:0] held_addr;
    logic              held_valid;

    logic rom_hit;
    logic rom_miss;

    assign rom_hit  = held_valid && (addr == held_addr);
    assign rom_miss = rom_cs && !rom_hit;

    // combinational so the core stops in the same cycle
    assign gate = !bus_busy && !rom_miss;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= idle;
            rom_req    <= 1'b0;
            rom_latch  <= 1'b0;
            held_valid <= 1'b0;
        end else begin
            // single clock pulse
            rom_latch <= 1'b0;
            case (state)
                idle: begin
                    // bus sharing wins over a new fetch
                    if (bus_busy) begin
                        state <= bus_hold;
                    end else if (rom_miss && !rom_ack) begin
                        // the port shadows the state label here
                        state   <= sys6809_pkg::rom_req;
                        rom_req <= 1'b1;
                    end
                end
                sys6809_pkg::rom_req: begin
                    // wait for the byte
                    if (rom_ack) begin
                        state     <= rom_rel;
                        rom_req   <= 1'b0;
                        rom_latch <= 1'b1;
                    end
                end
                rom_rel: begin
                    // byte is latched now, address matches next cycle
                    if (rom_latch) begin
                        held_valid <= 1'b1;
                    end
                    // no new request until ack is gone
                    if (!rom_ack) begin
                        state <= idle;
                    end
                end
                bus_hold: begin
                    if (!bus_busy) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // request address and held address
    always_ff @(posedge clk) begin
        // captured when the request rises, stable until it falls
        if (state == idle && !bus_busy && rom_miss && !rom_ack) begin
            rom_addr <= addr;
        end
        if (state == rom_rel && rom_latch) begin
            held_addr <= rom_addr;
        end
    end

endmodule

// File: source/work_ram.sv
// single-port byte work RAM
// write and registered read on the Q enable
`timescale 1ns/1ps

module work_ram
    import sys6809_pkg::*;
(
    input  logic              clk,
    // core data phase
    input  logic              cen_q,
    input  logic              ram_cs,
    // high for a read cycle
    input  logic              rnw,
    input  logic [ram_aw-1:0] addr,
    input  logic [data_w-1:0] cpu_dout,
    output logic [data_w-1:0] ram_dout
);

    logic [data_w-1:0] mem [2**ram_aw];

    logic we;

    // core write cycle
    assign we = ram_cs && !rnw;

    always_ff @(posedge clk) begin
        if (cen_q) begin
            if (we) begin
                mem[addr] <= cpu_dout;
            end
            // read-before-write on the same address
            ram_dout <= mem[addr];
        end
    end

endmodule

// File: source/cpu_data_path.sv
// ROM byte latch and read-data selector for the core
`timescale 1ns/1ps

module cpu_data_path
    import sys6809_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    // pulse from the wait state machine
    input  logic              rom_latch,
    // byte from SDRAM
    input  logic [data_w-1:0] rom_data,
    input  logic              ram_cs,
    input  logic              rom_cs,
    // registered work RAM output
    input  logic [data_w-1:0] ram_dout,
    // external peripherals
    input  logic [data_w-1:0] io_din,
    output logic [data_w-1:0] cpu_din
);

    // last fetched ROM byte
    logic [data_w-1:0] rom_byte;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rom_byte <= '0;
        end else if (rom_latch) begin
            // rom_data still valid, ack not yet dropped
            rom_byte <= rom_data;
        end
    end

    // read mux
    // RAM first, then ROM, everything else from io
    always_comb begin
        if (ram_cs) begin
            cpu_din = ram_dout;
        end else if (rom_cs) begin
            cpu_din = rom_byte;
        end else begin
            cpu_din = io_din;
        end
    end

    // rom_byte only changes after a fetch
    // a repeated read of the same address keeps it

endmodule

// File: source/sys6809_bus.sv
// top level of the 6809 bus front end
// phase generator, wait FSM, work RAM and read data path
`timescale 1ns/1ps

module sys6809_bus
    import sys6809_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    // core input clock strobe
    input  logic              cen,
    // shared bus held elsewhere
    input  logic              bus_busy,
    // core side
    input  logic [addr_w-1:0] addr,
    input  logic              rnw,
    input  logic              ram_cs,
    input  logic              rom_cs,
    input  logic [data_w-1:0] cpu_dout,
    // SDRAM side
    input  logic              rom_ack,
    input  logic [data_w-1:0] rom_data,
    // peripherals
    input  logic [data_w-1:0] io_din,
    // core enables
    output logic              cen_e,
    output logic              cen_q,
    output logic [data_w-1:0] cpu_din,
    output logic [data_w-1:0] ram_dout,
    output logic              rom_req,
    output logic [addr_w-1:0] rom_addr,
    // low while the core is stalled
    output logic              waitn
);

    logic gate;
    logic rom_latch;

    assign waitn = gate;

    // enable generation
    cen_phase_gen u_phase (
        .clk   ( clk   ),
        .rstn  ( rstn  ),
        .cen   ( cen   ),
        .gate  ( gate  ),
        .cen_e ( cen_e ),
        .cen_q ( cen_q )
    );

    // stalls for bus sharing and ROM fetch
    bus_wait_fsm u_wait (
        .clk       ( clk       ),
        .rstn      ( rstn      ),
        .bus_busy  ( bus_busy  ),
        .rom_cs    ( rom_cs    ),
        .addr      ( addr      ),
        .rom_ack   ( rom_ack   ),
        .rom_req   ( rom_req   ),
        .rom_addr  ( rom_addr  ),
        .rom_latch ( rom_latch ),
        .gate      ( gate      )
    );

    // work RAM, low address bits only
    work_ram u_ram (
        .clk      ( clk                 ),
        .cen_q    ( cen_q               ),
        .ram_cs   ( ram_cs              ),
        .rnw      ( rnw                 ),
        .addr     ( addr[ram_aw-1:0]    ),
        .cpu_dout ( cpu_dout            ),
        .ram_dout ( ram_dout            )
    );

    // read byte for the core
    cpu_data_path u_data (
        .clk       ( clk       ),
        .rstn      ( rstn      ),
        .rom_latch ( rom_latch ),
        .rom_data  ( rom_data  ),
        .ram_cs    ( ram_cs    ),
        .rom_cs    ( rom_cs    ),
        .ram_dout  ( ram_dout  ),
        .io_din    ( io_din    ),
        .cpu_din   ( cpu_din   )
    );

endmodule

// File: verification/tb_clk_gen.sv
// testbench clock and reset generator
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // reset released on a falling edge like the other inputs
    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rstn <= 1'b1;
    end

endmodule

// File: verification/tb_sys6809_bus.sv
// testbench for the 6809 bus front end
// CPU-side stimulus, SDRAM responder, checks and watchdog
`timescale 1ns/1ps

module tb_sys6809_bus
    import sys6809_pkg::*;
;

    // cycle budget per test, used by the watchdog
    localparam int reset_len    = 20;
    localparam int cadence_len  = 120;
    localparam int gating_len   = 80;
    localparam int recovery_len = 320;
    localparam int rom_len      = 300;
    localparam int ram_len      = 400;
    localparam int margin_len   = 400;
    localparam int budget = reset_len + cadence_len + gating_len + recovery_len
                          + rom_len + ram_len + margin_len;

    logic clk, rstn, cen, bus_busy, rnw, ram_cs, rom_cs, rom_ack;
    logic cen_e, cen_q, rom_req, waitn;
    logic [addr_w-1:0] addr, rom_addr;
    logic [data_w-1:0] cpu_dout, rom_data, io_din, cpu_din, ram_dout;

    integer seed = 32'h936435f1;
    int errors = 0;
    int tests_done = 0;

    // expected cadence model
    logic [1:0] mph;
    int mdebt;
    // enable counting window
    bit win_arm, win_on, win_close, win_done;
    int win_g, win_e, win_k;
    // handshake history
    logic req_d, ack_d, rst_d;
    logic [addr_w-1:0] raddr_d;
    int req_rises = 0;
    bit ack_rose;
    int q_count = 0;
    int visits [4];
    logic [data_w-1:0] shadow [2**ram_aw];

    tb_clk_gen #(.period_ns(40), .reset_cycles(16)) u_clk (.clk(clk), .rstn(rstn));

    sys6809_bus uut (
        .clk(clk), .rstn(rstn), .cen(cen), .bus_busy(bus_busy),
        .addr(addr), .rnw(rnw), .ram_cs(ram_cs), .rom_cs(rom_cs),
        .cpu_dout(cpu_dout), .rom_ack(rom_ack), .rom_data(rom_data),
        .io_din(io_din), .cen_e(cen_e), .cen_q(cen_q), .cpu_din(cpu_din),
        .ram_dout(ram_dout), .rom_req(rom_req), .rom_addr(rom_addr),
        .waitn(waitn)
    );

    task automatic log_failure(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    // SDRAM content rule
    function automatic logic [data_w-1:0] rom_byte_for(input logic [addr_w-1:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    // core strobe every second clock from time zero
    always @(negedge clk) begin
        cen <= ~cen;
    end

    // SDRAM responder, four-phase
    initial begin
        int d;
        rom_ack = 1'b0;
        rom_data = '0;
        forever begin
            @(negedge clk);
            if (rom_req && !rom_ack) begin
                d = $random(seed) & 7;
                repeat (d) @(negedge clk);
                rom_data = rom_byte_for(rom_addr);
                rom_ack = 1'b1;
                while (rom_req) @(negedge clk);
                d = $random(seed) & 3;
                repeat (d) @(negedge clk);
                rom_ack = 1'b0;
            end
        end
    end

    // checks, sampled on the rising edge
    always @(posedge clk) begin
        logic en;
        logic exp_e;
        logic exp_q;
        int debt_before;
        en = cen_e | cen_q;
        visits[uut.u_wait.state]++;
        assert (!(cen_e && cen_q)) else log_failure("cen_e and cen_q fired together");
        assert (waitn || !en) else log_failure("enable fired while waitn low");
        assert (!bus_busy || !waitn) else log_failure("waitn high while bus_busy");
        if (!rstn) begin
            assert (waitn && !en) else log_failure("enable or waitn wrong in reset");
            // rom_req is settled from the first reset edge on
            if (rst_d === 1'b0) begin
                assert (!rom_req) else log_failure("rom_req high in reset");
            end
            mph = 2'd0;
            mdebt = 0;
        end else begin
            if (!rst_d) begin
                assert (!rom_req && waitn) else log_failure("outputs wrong after reset");
            end
            // four-phase rules
            if (rom_req && !req_d) begin
                req_rises++;
                assert (!ack_d) else log_failure("rom_req rose while rom_ack high");
            end
            if (rom_req && req_d) begin
                assert (rom_addr == raddr_d) else log_failure("rom_addr moved during request");
            end
            if (!rom_req && req_d) begin
                assert (ack_d) else log_failure("rom_req fell before rom_ack");
            end
            if (rom_ack && !ack_d) ack_rose = 1'b1;
            if (cen_q) q_count++;
            if (cen) begin
                exp_e = waitn && mph == 2'd0;
                exp_q = waitn && mph == 2'd2;
                assert (cen_e == exp_e && cen_q == exp_q)
                    else log_failure("enable cadence differs from expected");
                debt_before = mdebt;
                // window from one enable to the first enable with no debt left
                if (win_arm && en) begin
                    win_arm = 1'b0;
                    win_on = 1'b1;
                    win_g = 1;
                    win_e = 1;
                    win_k = 0;
                end else if (win_on && waitn) begin
                    win_g++;
                    if (en) win_e++;
                    if (en && win_close && debt_before == 0) begin
                        win_on = 1'b0;
                        win_done = 1'b1;
                    end
                end
                if (waitn) begin
                    if (mdebt != 0 && !mph[0]) begin
                        // repayment, next enable one strobe away
                        mph = mph ^ 2'd2;
                        mdebt--;
                    end else begin
                        mph = mph + 2'd1;
                    end
                end else if (!mph[0] && mdebt != 15) begin
                    mdebt++;
                    if (win_on) win_k++;
                end
            end else begin
                assert (!en) else log_failure("enable fired without cen");
            end
        end
        req_d = rom_req;
        ack_d = rom_ack;
        raddr_d = rom_addr;
        rst_d = rstn;
    end

    task automatic finish_test(input string name, input int errs_before);
        tests_done++;
        $display("test %s finished, %0d errors", name, errors - errs_before);
    endtask

    // count enables over a window with an optional stall at phase 2
    task automatic run_window(input int stall);
        int guard;
        int k_exp;
        win_done = 1'b0;
        win_close = 1'b0;
        win_arm = 1'b1;
        guard = 0;
        while (!win_on && guard < 20) begin
            @(negedge clk);
            guard++;
        end
        repeat (8) @(negedge clk);
        if (stall > 0) begin
            guard = 0;
            while (!(cen == 1'b0 && mph == 2'd2) && guard < 20) begin
                @(negedge clk);
                guard++;
            end
            bus_busy = 1'b1;
            repeat (2 * stall) @(negedge clk);
            bus_busy = 1'b0;
        end
        repeat (10) @(negedge clk);
        win_close = 1'b1;
        guard = 0;
        while (!win_done && guard < 100) begin
            @(negedge clk);
            guard++;
        end
        win_close = 1'b0;
        if (!win_done) begin
            log_failure("enable count window never closed");
        end else begin
            k_exp = (stall > 15) ? 15 : stall;
            assert (win_k == k_exp) else log_failure("missed slot count wrong");
            assert (2 * win_e == win_g + 1 + win_k)
                else log_failure("enable total does not match strobes plus misses");
        end
    endtask

    task automatic rom_read(input logic [addr_w-1:0] a, input bit fetch);
        int n0;
        int guard;
        n0 = req_rises;
        ack_rose = 1'b0;
        addr = a;
        rom_cs = 1'b1;
        ram_cs = 1'b0;
        rnw = 1'b1;
        @(negedge clk);
        guard = 0;
        while (!waitn && guard < 60) begin
            @(negedge clk);
            guard++;
        end
        if (!waitn) log_failure("ROM read never finished");
        if (fetch) begin
            assert (ack_rose) else log_failure("waitn rose before rom_ack");
        end
        assert (cpu_din == rom_byte_for(a)) else log_failure("ROM byte mismatch");
        repeat (4) @(negedge clk);
        if (!fetch) begin
            assert (req_rises == n0) else log_failure("repeated ROM read fetched again");
        end
        rom_cs = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_for_q();
        int c;
        int guard;
        c = q_count;
        guard = 0;
        while (q_count == c && guard < 12) begin
            @(negedge clk);
            guard++;
        end
        if (q_count == c) log_failure("no cen_q arrived for a RAM access");
    endtask

    task automatic ram_write(input logic [ram_aw-1:0] a, input logic [data_w-1:0] d);
        addr = {4'h0, a};
        ram_cs = 1'b1;
        rnw = 1'b0;
        cpu_dout = d;
        wait_for_q();
        ram_cs = 1'b0;
        rnw = 1'b1;
        shadow[a] = d;
    endtask

    task automatic ram_read(input logic [ram_aw-1:0] a);
        addr = {4'h0, a};
        ram_cs = 1'b1;
        rnw = 1'b1;
        wait_for_q();
        assert (ram_dout == shadow[a]) else log_failure("ram_dout differs from byte written");
        assert (cpu_din == shadow[a]) else log_failure("RAM read byte mismatch");
        ram_cs = 1'b0;
    endtask

    // watchdog
    initial begin
        repeat (budget) @(posedge clk);
        $display("watchdog expired, the run took longer than its cycle budget");
        $display("Errors found");
        $finish;
    end

    initial begin
        int e0;
        logic [ram_aw-1:0] wa [$];
        logic [ram_aw-1:0] a;
        wait_state_t s;
        cen = 1'b0;
        bus_busy = 1'b0;
        addr = '0;
        rnw = 1'b1;
        ram_cs = 1'b0;
        rom_cs = 1'b0;
        cpu_dout = '0;
        io_din = '0;

        e0 = errors;
        @(posedge rstn);
        repeat (3) @(negedge clk);
        finish_test("reset state", e0);

        e0 = errors;
        run_window(0);
        finish_test("unstalled cadence", e0);

        // short stall at whatever phase comes up
        e0 = errors;
        repeat (3) @(negedge clk);
        bus_busy = 1'b1;
        repeat (3) @(negedge clk);
        bus_busy = 1'b0;
        repeat (40) @(negedge clk);
        finish_test("gating", e0);

        e0 = errors;
        run_window(6);
        run_window(20);
        finish_test("slot recovery", e0);

        e0 = errors;
        rom_read(16'hc123, 1'b1);
        rom_read(16'hc123, 1'b0);
        rom_read(16'hf00e, 1'b1);
        rom_read(16'h8a5c, 1'b1);
        rom_read(16'h8a5c, 1'b0);
        finish_test("ROM handshake", e0);

        e0 = errors;
        for (int i = 0; i < 14; i++) begin
            a = $random(seed);
            wa.push_back(a);
            ram_write(a, $random(seed));
        end
        // overwrite one address, the last write must win
        ram_write(wa[3], 8'ha7);
        foreach (wa[i]) ram_read(wa[i]);
        io_din = $random(seed);
        @(posedge clk);
        assert (cpu_din == io_din) else log_failure("io byte not selected");
        finish_test("work RAM", e0);

        for (int i = 0; i < 4; i++) begin
            s = wait_state_t'(i);
            $display("fsm state %s visited in %0d cycles", s.name(), visits[i]);
        end
        $display("tests run %0d, checks failed %0d", tests_done, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: project.f
common/sys6809_pkg.sv
source/cen_phase_gen.sv
source/bus_wait_fsm.sv
source/work_ram.sv
source/cpu_data_path.sv
source/sys6809_bus.sv
verification/tb_clk_gen.sv
verification/tb_sys6809_bus.sv

// File: Bender.yml
package:
  name: sys6809_bus

sources:
  - common/sys6809_pkg.sv
  - source/cen_phase_gen.sv
  - source/bus_wait_fsm.sv
  - source/work_ram.sv
  - source/cpu_data_path.sv
  - source/sys6809_bus.sv
  - target: simulation
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_sys6809_bus.sv
